//--- logic/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ============================================================
  // Widths and sizes
  // ============================================================
  localparam int sample_w   = 8;
  localparam int div_w      = 17;
  localparam int count_w    = 16;
  localparam int num_digits = 8;
  localparam int num_leds   = 8;

  // ============================================================
  // Note table and audio words
  // ============================================================
  // Half-period counts, Do through high Do
  localparam logic [div_w-1:0] note_div [0:7] = '{
    17'h0BAB9,
    17'h0A65D,
    17'h09430,
    17'h08BE9,
    17'h07CB8,
    17'h06EF9,
    17'h062F1,
    17'h05D5C
  };

  // Signed square wave levels
  localparam logic [sample_w-1:0] tone_low_sample  = 8'h80;
  localparam logic [sample_w-1:0] tone_high_sample = 8'h01;

  // Scope sampling count, 2 kHz at 50 MHz
  localparam logic [count_w-1:0] default_sample_count = 16'd12499;
  localparam logic [count_w-1:0] speed_step           = 16'd100;

  // Tick periods in CLK_50M cycles
  localparam int default_refresh_div = 25_000_000;
  localparam int default_led_div     = 50_000_000;
  localparam int default_event_div   = 5_000_000;

  // ============================================================
  // Types
  // ============================================================
  typedef struct packed {
    logic [2:0] note_code;
    logic       audio_on;
  } organ_sw_t;

  // All keys active low
  typedef struct packed {
    logic led_restart;
    logic speed_clear;
    logic speed_down;
    logic speed_up;
  } organ_keys_t;

  // Up and down are one-cycle pulses, clear is a level
  typedef struct packed {
    logic up;
    logic down;
    logic clear;
  } speed_evt_t;

  // Active-low segments, a in bit 0
  typedef logic [num_digits-1:0][6:0] seg_bus_t;

  typedef union packed {
    logic [num_digits*4-1:0]      count;
    logic [num_digits-1:0][3:0]   nibble;
  } disp_word_u;

endpackage

`default_nettype wire

//--- logic/note_tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module note_tone_gen (
  input  wire logic                          CLK_50M,
  input  wire logic                          rst_n,
  input  wire organ_pkg::organ_sw_t          sw,
  output logic [organ_pkg::sample_w-1:0]     audio_sample
);

  logic [organ_pkg::div_w-1:0] half_period;
  logic [organ_pkg::div_w-1:0] tone_cnt;
  logic                        tone;

  // Switch code selects the divider count
  assign half_period = organ_pkg::note_div[sw.note_code];

  // ============================================================
  // Tone divider
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      tone_cnt <= '0;
      tone     <= 1'b0;
    end
    else if (!sw.audio_on)
    begin
      tone_cnt <= '0;
      tone     <= 1'b0;
    end
    // >= so a switch to a shorter note never overshoots
    else if (tone_cnt >= half_period)
    begin
      tone_cnt <= '0;
      tone     <= ~tone;
    end
    else
    begin
      tone_cnt <= tone_cnt + 1'b1;
    end
  end

  // Sample follows the tone flop directly
  always_comb
  begin
    if (!sw.audio_on)
      audio_sample = '0;
    else if (tone)
      audio_sample = organ_pkg::tone_high_sample;
    else
      audio_sample = organ_pkg::tone_low_sample;
  end

endmodule

`default_nettype wire

//--- logic/speed_control.sv
`timescale 1ns/1ps
`default_nettype none

module speed_control #(
  parameter int event_div = organ_pkg::default_event_div
) (
  input  wire logic                        CLK_50M,
  input  wire logic                        rst_n,
  input  wire organ_pkg::organ_keys_t      keys,
  output logic [organ_pkg::count_w-1:0]    sample_count
);

  // Bit order: clear, down, up
  logic [2:0]                         key_meta;
  logic [2:0]                         key_sync;
  logic [$clog2(event_div+1)-1:0]     win_cnt;
  logic                               win_tick;
  organ_pkg::speed_evt_t              evt;
  logic signed [organ_pkg::count_w-1:0] speed;

  // ============================================================
  // Key synchronizers, keys pressed when low
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= ~{keys.speed_clear, keys.speed_down, keys.speed_up};
      key_sync <= key_meta;
    end
  end

  // Repeat window, limits how fast a held key steps
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      win_cnt <= '0;
    else if (win_tick)
      win_cnt <= '0;
    else
      win_cnt <= win_cnt + 1'b1;
  end

  assign win_tick = (win_cnt == event_div - 1);

  assign evt.up    = win_tick & key_sync[0];
  assign evt.down  = win_tick & key_sync[1];
  assign evt.clear = key_sync[2];

  // ============================================================
  // Speed value, two's complement, wraps at 16 bits
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      speed <= '0;
    else if (evt.clear)
      speed <= '0;
    else if (evt.up)
      speed <= speed + organ_pkg::speed_step;
    else if (evt.down)
      speed <= speed - organ_pkg::speed_step;
  end

  // Sampling divider count, one cycle behind the speed value
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
      sample_count <= organ_pkg::default_sample_count;
    else
      sample_count <= organ_pkg::default_sample_count + speed;
  end

endmodule

`default_nettype wire

//--- logic/seg7_display.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_display #(
  parameter int refresh_div = organ_pkg::default_refresh_div
) (
  input  wire logic                        CLK_50M,
  input  wire logic                        rst_n,
  input  wire [organ_pkg::count_w-1:0]     sample_count,
  output organ_pkg::seg_bus_t              hex
);

  logic [$clog2(refresh_div+1)-1:0] ref_cnt;
  organ_pkg::disp_word_u            disp;

  // Hex digit to active-low segments, a in bit 0 and g in bit 6
  function automatic logic [6:0] hex_to_seg(input logic [3:0] nib);
    case (nib)
      4'h0: hex_to_seg = 7'h40;
      4'h1: hex_to_seg = 7'h79;
      4'h2: hex_to_seg = 7'h24;
      4'h3: hex_to_seg = 7'h30;
      4'h4: hex_to_seg = 7'h19;
      4'h5: hex_to_seg = 7'h12;
      4'h6: hex_to_seg = 7'h02;
      4'h7: hex_to_seg = 7'h78;
      4'h8: hex_to_seg = 7'h00;
      4'h9: hex_to_seg = 7'h10;
      4'hA: hex_to_seg = 7'h08;
      4'hB: hex_to_seg = 7'h03;
      4'hC: hex_to_seg = 7'h46;
      4'hD: hex_to_seg = 7'h21;
      4'hE: hex_to_seg = 7'h06;
      default: hex_to_seg = 7'h0E;
    endcase
  endfunction

  // Slow refresh so the digits stay readable
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      ref_cnt    <= '0;
      disp.count <= {{(organ_pkg::num_digits*4-organ_pkg::count_w){1'b0}},
                     organ_pkg::default_sample_count};
    end
    else if (ref_cnt == refresh_div - 1)
    begin
      ref_cnt    <= '0;
      disp.count <= {{(organ_pkg::num_digits*4-organ_pkg::count_w){1'b0}}, sample_count};
    end
    else
    begin
      ref_cnt <= ref_cnt + 1'b1;
    end
  end

  // One decoder per nibble
  always_comb
  begin
    for (int i = 0; i < organ_pkg::num_digits; i++)
      hex[i] = hex_to_seg(disp.nibble[i]);
  end

endmodule

`default_nettype wire

//--- logic/led_ping_pong.sv
`timescale 1ns/1ps
`default_nettype none

module led_ping_pong #(
  parameter int led_div = organ_pkg::default_led_div
) (
  input  wire logic                         CLK_50M,
  input  wire logic                         rst_n,
  input  wire logic                         restart_n,
  output logic [organ_pkg::num_leds-1:0]    led
);

  logic                          restart_meta;
  logic                          restart_sync;
  logic [$clog2(led_div+1)-1:0]  step_cnt;
  logic                          step_tick;
  logic                          dir_up;

  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n)
    begin
      restart_meta <= 1'b0;
      restart_sync <= 1'b0;
    end
    else
    begin
      restart_meta <= ~restart_n;
      restart_sync <= restart_meta;
    end
  end

  assign step_tick = (step_cnt == led_div - 1);

  // ============================================================
  // Step counter and bouncing one-hot position
  // ============================================================
  always_ff @(posedge CLK_50M)
  begin
    if (!rst_n || restart_sync)
    begin
      step_cnt <= '0;
      led      <= 1;
      dir_up   <= 1'b1;
    end
    else if (step_tick)
    begin
      step_cnt <= '0;
      // Turn around at either end
      if (dir_up && led[organ_pkg::num_leds-1])
      begin
        led    <= led >> 1;
        dir_up <= 1'b0;
      end
      else if (!dir_up && led[0])
      begin
        led    <= led << 1;
        dir_up <= 1'b1;
      end
      else if (dir_up)
        led <= led << 1;
      else
        led <= led >> 1;
    end
    else
      step_cnt <= step_cnt + 1'b1;
  end

endmodule

`default_nettype wire

//--- logic/basic_organ.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ #(
  parameter int refresh_div = organ_pkg::default_refresh_div,
  parameter int led_div     = organ_pkg::default_led_div,
  parameter int event_div   = organ_pkg::default_event_div
) (
  input  wire logic                         CLK_50M,
  input  wire logic                         rst_n,
  input  wire organ_pkg::organ_sw_t         sw,
  input  wire organ_pkg::organ_keys_t       keys,
  output logic [organ_pkg::sample_w-1:0]    audio_sample,
  output organ_pkg::seg_bus_t               hex,
  output logic [organ_pkg::num_leds-1:0]    led
);

  logic [organ_pkg::count_w-1:0] sample_count;

  // ============================================================
  // Tone path
  // ============================================================
  note_tone_gen tone0 (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .audio_sample (audio_sample)
  );

  // Speed keys drive the count shown on the display
  speed_control #(.event_div(event_div)) speed0 (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .keys         (keys),
    .sample_count (sample_count)
  );

  seg7_display #(.refresh_div(refresh_div)) disp0 (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sample_count (sample_count),
    .hex          (hex)
  );

  led_ping_pong #(.led_div(led_div)) leds0 (
    .CLK_50M   (CLK_50M),
    .rst_n     (rst_n),
    .restart_n (keys.led_restart),
    .led       (led)
  );

endmodule

`default_nettype wire

//--- verif/basic_organ_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ_assertions (
  input wire logic                CLK_50M,
  input wire logic                rst_n,
  input wire logic [7:0]          audio_sample,
  input wire organ_pkg::seg_bus_t hex,
  input wire logic [7:0]          led
);

  // Exactly one LED lit at any time
  led_onehot: assert property (@(posedge CLK_50M) disable iff (!rst_n) $onehot(led))
    else $error("led is not one-hot: %b", led);

  // Only silence or one of the two square wave levels
  audio_levels: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (audio_sample == 8'h00) || (audio_sample == 8'h01) || (audio_sample == 8'h80))
    else $error("audio_sample has an illegal level: %h", audio_sample);

  // Count is 16 bits, so digits 4 to 7 always read 0
  upper_digits_zero: assert property (@(posedge CLK_50M) disable iff (!rst_n)
    (hex[7] == 7'h40) && (hex[6] == 7'h40) && (hex[5] == 7'h40) && (hex[4] == 7'h40))
    else $error("upper display digits are not zero");

endmodule

bind basic_organ basic_organ_assertions asrt0 (.*);

`default_nettype wire

//--- verif/basic_organ_tb.sv
`timescale 1ns/1ps
`default_nettype none

module basic_organ_tb;

  // Short tick periods so the run stays small
  localparam int refresh_div = 40;
  localparam int led_div     = 30;
  localparam int event_div   = 50;

  logic                   CLK_50M;
  logic                   rst_n;
  organ_pkg::organ_sw_t   sw;
  organ_pkg::organ_keys_t keys;
  logic [7:0]             audio_sample;
  organ_pkg::seg_bus_t    hex;
  logic [7:0]             led;
  logic [15:0]            lfsr;

  basic_organ #(
    .refresh_div (refresh_div),
    .led_div     (led_div),
    .event_div   (event_div)
  ) dut0 (
    .CLK_50M      (CLK_50M),
    .rst_n        (rst_n),
    .sw           (sw),
    .keys         (keys),
    .audio_sample (audio_sample),
    .hex          (hex),
    .led          (led)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ============================================================
  // Reference models
  // ============================================================
  // Lit segments gfedcba per hex digit, board drives them low
  function automatic logic [6:0] seg_ref(input logic [3:0] nib);
    logic [6:0] lit [0:15];
    lit = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
            7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
    return ~lit[nib];
  endfunction

  function automatic organ_pkg::seg_bus_t segs_for(input logic [31:0] value);
    organ_pkg::seg_bus_t s;
    for (int i = 0; i < 8; i++)
      s[i] = seg_ref(value[i*4 +: 4]);
    return s;
  endfunction

  // Reads the digits back as a number, X where a digit is not a hex glyph
  function automatic logic [31:0] shown_value(input organ_pkg::seg_bus_t s);
    logic [31:0] value;
    value = 'x;
    for (int i = 0; i < 8; i++)
      for (int n = 0; n < 16; n++)
        if (seg_ref(n[3:0]) == s[i])
          value[i*4 +: 4] = n[3:0];
    return value;
  endfunction

  // Bounce repeats every 14 steps: 0..7 then 6..1
  function automatic logic [7:0] led_ref(input int step);
    int m;
    m = step % 14;
    return (m < 8) ? (8'h01 << m) : (8'h01 << (14 - m));
  endfunction

  function automatic int half_period_ref(input logic [2:0] code);
    return organ_pkg::note_div[code] + 1;
  endfunction

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic draw_bits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++)
    begin
      lfsr  = lfsr_next(lfsr);
      value = (value << 1) | lfsr[0];
    end
  endtask

  // ============================================================
  // Checks and waits
  // ============================================================
  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act)
    begin
      $display("MISMATCH %s expected %0h actual %0h", name, exp, act);
      $display("*** TEST FAILED ***");
      $fatal(1, "check %s failed", name);
    end
  endtask

  task automatic give_up(input string what);
    $display("Timed out waiting for %s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "timeout");
  endtask

  task automatic step_to_drive();
    @(posedge CLK_50M);
    #2;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge CLK_50M);
  endtask

  task automatic wait_audio_change(input int limit, output int cycles);
    logic [7:0] prev;
    prev   = audio_sample;
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
      if (cycles > limit)
        give_up("audio_sample to change");
    end
    while (audio_sample === prev);
  endtask

  task automatic wait_led_change(input int limit);
    logic [7:0] prev;
    int         cycles;
    prev   = led;
    cycles = 0;
    do
    begin
      @(negedge CLK_50M);
      cycles++;
      if (cycles > limit)
        give_up("led to move");
    end
    while (led === prev);
  endtask

  task automatic wait_led_home(input int limit);
    int cycles;
    cycles = 0;
    while (led !== 8'h01)
    begin
      @(negedge CLK_50M);
      cycles++;
      if (cycles > limit)
        give_up("led to return to LED 0");
    end
  endtask

  // Holds one active-low key for a random time, then lets it go
  task automatic hold_speed_key(input bit up);
    int r;
    draw_bits(7, r);
    step_to_drive();
    if (up)
      keys.speed_up = 1'b0;
    else
      keys.speed_down = 1'b0;
    wait_cycles(2 * event_div + 20 + r);
    step_to_drive();
    keys.speed_up   = 1'b1;
    keys.speed_down = 1'b1;
    wait_cycles(2 * refresh_div + 4);
  endtask

  // ============================================================
  // Main sequence
  // ============================================================
  initial
  begin : main_flow
    int          order [0:7];
    int          r;
    int          j;
    int          tmp;
    int          gap;
    logic [31:0] value;

    sw     = '0;
    keys   = '1;
    rst_n  = 1'b0;
    lfsr   = 16'd46;
    repeat (2) @(posedge CLK_50M);
    #2 rst_n = 1'b1;
    @(negedge CLK_50M);

    compare("reset audio", 8'h00, audio_sample);
    compare("reset led", 8'h01, led);
    compare("reset hex", segs_for(32'h000030D3), hex);

    // LED bounce from reset, across both turning points
    for (int k = 0; k < 20; k++)
    begin
      wait_led_change(led_div + 5);
      compare("led bounce", led_ref(k + 1), led);
    end
    step_to_drive();
    keys.led_restart = 1'b0;
    repeat (3) step_to_drive();
    keys.led_restart = 1'b1;
    wait_led_home(10);
    for (int k = 0; k < 10; k++)
    begin
      wait_led_change(led_div + 10);
      compare("led after restart", led_ref(k + 1), led);
    end

    // Note order shuffled by the LFSR
    for (int i = 0; i < 8; i++)
      order[i] = i;
    for (int i = 7; i > 0; i--)
    begin
      draw_bits(3, r);
      j        = r % (i + 1);
      tmp      = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < 8; i++)
    begin
      step_to_drive();
      sw.note_code = order[i];
      sw.audio_on  = 1'b0;
      step_to_drive();
      sw.audio_on = 1'b1;
      @(negedge CLK_50M);
      compare("tone start", 8'h80, audio_sample);
      wait_audio_change(half_period_ref(order[i]) + 5, gap);
      compare("tone high", 8'h01, audio_sample);
      wait_audio_change(half_period_ref(order[i]) + 5, gap);
      compare("tone half period", half_period_ref(order[i]), gap);
      compare("tone low", 8'h80, audio_sample);
    end
    step_to_drive();
    sw.audio_on = 1'b0;

    // Speed up, then steady once released
    hold_speed_key(1'b1);
    value = shown_value(hex);
    compare("speed up step", 0, (value - 32'd12499) % 100);
    compare("speed up sign", 1, value > 32'd12499);
    wait_cycles(refresh_div);
    compare("speed up steady", value, shown_value(hex));

    // Clear, then speed down
    step_to_drive();
    keys.speed_clear = 1'b0;
    wait_cycles(2 * refresh_div + 4);
    compare("speed clear", 32'd12499, shown_value(hex));
    step_to_drive();
    keys.speed_clear = 1'b1;
    hold_speed_key(1'b0);
    value = shown_value(hex);
    compare("speed down step", 0, (32'd12499 - value) % 100);
    compare("speed down sign", 1, value < 32'd12499);

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- basic_organ.f
logic/organ_pkg.sv
logic/note_tone_gen.sv
logic/speed_control.sv
logic/seg7_display.sv
logic/led_ping_pong.sv
logic/basic_organ.sv
verif/basic_organ_assertions.sv
verif/basic_organ_tb.sv

//--- Bender.yml
package:
  name: basic_organ

sources:
  - logic/organ_pkg.sv
  - logic/note_tone_gen.sv
  - logic/speed_control.sv
  - logic/seg7_display.sv
  - logic/led_ping_pong.sv
  - logic/basic_organ.sv
  - target: test
    files:
      - verif/basic_organ_assertions.sv
      - verif/basic_organ_tb.sv
